// ==== logic/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module free_list import rename_pkg::*; (
  input  logic        global_bus,
  input  logic        rst_n,
  input  logic [1:0]  alloc_num,
  input  logic        free_valid,
  input  phys_tag_t   free_tag,
  output phys_tag_t   alloc_tag_0,
  output phys_tag_t   alloc_tag_1,
  output free_count_t avail
);

  localparam int FL_DEPTH = `RN_PHYS_REGS - `RN_ARCH_REGS;
  localparam int PTR_W    = $clog2(FL_DEPTH);

  phys_tag_t        fifo_q [FL_DEPTH];
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  free_count_t      count_q;

  // ====================
  // Head view
  // ====================
  always_comb begin
    alloc_tag_0 = fifo_q[head_q];
    alloc_tag_1 = fifo_q[head_q + PTR_W'(1)];   // Wraps around the ring
    avail       = count_q;
  end

  // ====================
  // Pointers and count
  // ====================
  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;                      // Full ring, tail meets head
      count_q <= free_count_t'(FL_DEPTH);
    end else begin
      head_q  <= head_q + PTR_W'(alloc_num);
      count_q <= count_q - free_count_t'(alloc_num) + free_count_t'(free_valid);
      if (free_valid) begin
        tail_q <= tail_q + PTR_W'(1);
      end
    end
  end

  // ====================
  // Tag storage
  // ====================
  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      for (int i = 0; i < FL_DEPTH; i++) begin
        fifo_q[i] <= phys_tag_t'(`RN_ARCH_REGS + i);   // Tags above the arch set
      end
    end else if (free_valid) begin
      fifo_q[tail_q] <= free_tag;
    end
  end

endmodule

`default_nettype wire

// ==== logic/ip_resolver.sv ====
`timescale 1ns/1ps
`default_nettype none

module ip_resolver import rename_pkg::*; (
  input  logic              global_bus,
  input  logic              rst_n,
  input  decoded_bundle_t   in_bundle,
  input  logic              branch_resolve,
  input  phys_tag_t [3:0]   src_tag,
  input  phys_tag_t         alloc_tag_0,
  input  phys_tag_t         alloc_tag_1,
  input  free_count_t       avail,
  output arch_reg_t [3:0]   src_reg,
  output logic      [1:0]   alloc_num,
  output logic      [1:0]   map_wr_en,
  output arch_reg_t [1:0]   map_wr_reg,
  output phys_tag_t [1:0]   map_wr_tag,
  output renamed_bundle_t   out_bundle,
  output logic              stop
);

  decoded_instr_t  s0;
  decoded_instr_t  s1;
  logic            need_0;
  logic            need_1;
  logic [1:0]      num_need;
  logic            offered;
  logic            accept;
  logic            has_jump;
  phys_tag_t       rn_0;
  phys_tag_t       rn_1;
  renamed_bundle_t ren;
  renamed_bundle_t out_q;
  logic [1:0]      out_vld_q;
  logic            tag_active;

  // ====================
  // Allocation and stop
  // ====================
  always_comb begin
    s0       = in_bundle.slot_0;
    s1       = in_bundle.slot_1;
    need_0   = s0.valid && s0.writes && (s0.rd != '0);
    need_1   = s1.valid && s1.writes && (s1.rd != '0);
    num_need = 2'(need_0) + 2'(need_1);
    offered  = s0.valid || s1.valid;
    stop     = offered && (free_count_t'(num_need) > avail);
    accept   = offered && !stop;
    has_jump = (s0.valid && s0.jumps) || (s1.valid && s1.jumps);
    rn_0     = need_0 ? alloc_tag_0 : '0;
    rn_1     = need_1 ? (need_0 ? alloc_tag_1 : alloc_tag_0) : '0;   // Next free head
    alloc_num = accept ? num_need : 2'd0;
    src_reg  = {s1.rs_2, s1.rs_1, s0.rs_2, s0.rs_1};
    map_wr_en  = {accept && need_1, accept && need_0};
    map_wr_reg = {s1.rd, s0.rd};
    map_wr_tag = {rn_1, rn_0};
  end

  // ====================
  // Renamed bundle
  // ====================
  always_comb begin
    ren.slot_0.valid   = s0.valid;
    ren.slot_0.address = s0.address;
    ren.slot_0.rs_1    = src_tag[0];
    ren.slot_0.rs_2    = src_tag[1];
    ren.slot_0.rd      = s0.rd;
    ren.slot_0.rn      = rn_0;
    ren.slot_0.writes  = s0.writes;
    ren.slot_0.jumps   = s0.jumps;
    ren.slot_0.tag     = s0.jumps ? 1'b0 : tag_active;

    ren.slot_1.valid   = s1.valid;
    ren.slot_1.address = s1.address;
    ren.slot_1.rs_1    = (need_0 && s0.rd == s1.rs_1) ? rn_0 : src_tag[2];   // In-bundle bypass
    ren.slot_1.rs_2    = (need_0 && s0.rd == s1.rs_2) ? rn_0 : src_tag[3];
    ren.slot_1.rd      = s1.rd;
    ren.slot_1.rn      = rn_1;
    ren.slot_1.writes  = s1.writes;
    ren.slot_1.jumps   = s1.jumps;
    if (s1.jumps) ren.slot_1.tag = 1'b0;
    else if (s0.jumps) ren.slot_1.tag = 1'b1;    // Behind slot 0's jump
    else ren.slot_1.tag = tag_active;
  end

  // ====================
  // Control state
  // ====================
  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      tag_active <= 1'b0;
      out_vld_q  <= 2'b00;
    end else begin
      out_vld_q <= accept ? {s1.valid, s0.valid} : 2'b00;
      if (accept && has_jump) tag_active <= 1'b1;   // Set beats resolve
      else if (branch_resolve) tag_active <= 1'b0;
    end
  end

  always_ff @(posedge global_bus) begin
    if (accept) begin
      out_q <= ren;
    end
  end

  always_comb begin
    out_bundle              = out_q;
    out_bundle.slot_0.valid = out_vld_q[0];
    out_bundle.slot_1.valid = out_vld_q[1];
  end

endmodule

`default_nettype wire

// ==== logic/map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module map_table import rename_pkg::*; (
  input  logic                global_bus,
  input  logic                rst_n,
  input  arch_reg_t [3:0]     rd_reg,
  output phys_tag_t [3:0]     rd_tag,
  input  logic      [1:0]     wr_en,
  input  arch_reg_t [1:0]     wr_reg,
  input  phys_tag_t [1:0]     wr_tag
);

  phys_tag_t map_q [`RN_ARCH_REGS];

  // ====================
  // Source lookups
  // ====================
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      rd_tag[i] = map_q[rd_reg[i]];
    end
  end

  // ====================
  // Updates
  // ====================
  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      for (int i = 0; i < `RN_ARCH_REGS; i++) begin
        map_q[i] <= phys_tag_t'(i);       // Identity map
      end
    end else begin
      if (wr_en[0]) begin
        map_q[wr_reg[0]] <= wr_tag[0];
      end
      if (wr_en[1]) begin
        map_q[wr_reg[1]] <= wr_tag[1];    // Younger slot wins
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/rename_cfg.svh ====
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// ====================
// Register file sizes
// ====================
`define RN_ARCH_REGS 32
`define RN_PHYS_REGS 64

// ====================
// Fetch address
// ====================
`define RN_ADDR_W 32

`endif

// ==== logic/rename_pkg.sv ====
`default_nettype none

`include "rename_cfg.svh"

package rename_pkg;

  // ====================
  // Widths
  // ====================
  typedef logic [$clog2(`RN_ARCH_REGS)-1:0] arch_reg_t;
  typedef logic [$clog2(`RN_PHYS_REGS)-1:0] phys_tag_t;   // Tag 0 stays with r0
  typedef logic [`RN_ADDR_W-1:0] instr_addr_t;
  typedef logic [$clog2(`RN_PHYS_REGS):0] free_count_t;

  // ====================
  // Instruction records
  // ====================
  typedef struct packed {
    logic        valid;
    instr_addr_t address;
    arch_reg_t   rs_1;
    arch_reg_t   rs_2;
    arch_reg_t   rd;
    logic        writes;
    logic        jumps;
  } decoded_instr_t;

  typedef struct packed {
    logic        valid;
    instr_addr_t address;
    phys_tag_t   rs_1;     // Physical source tags
    phys_tag_t   rs_2;
    arch_reg_t   rd;
    phys_tag_t   rn;       // Newly allocated tag, 0 if none
    logic        writes;
    logic        jumps;
    logic        tag;      // Speculative, behind an open jump
  } renamed_instr_t;

  typedef struct packed {
    decoded_instr_t slot_1;
    decoded_instr_t slot_0;
  } decoded_bundle_t;

  typedef struct packed {
    renamed_instr_t slot_1;
    renamed_instr_t slot_0;
  } renamed_bundle_t;

endpackage

`default_nettype wire

// ==== logic/rename_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_top import rename_pkg::*; (
  input  logic            global_bus,
  input  logic            rst_n,
  input  decoded_bundle_t in_bundle,
  input  logic            free_valid,
  input  phys_tag_t       free_tag,
  input  logic            branch_resolve,
  output renamed_bundle_t out_bundle,
  output logic            stop
);

  arch_reg_t [3:0] src_reg;
  phys_tag_t [3:0] src_tag;
  phys_tag_t       alloc_tag_0;
  phys_tag_t       alloc_tag_1;
  free_count_t     avail;
  logic      [1:0] alloc_num;
  logic      [1:0] map_wr_en;
  arch_reg_t [1:0] map_wr_reg;
  phys_tag_t [1:0] map_wr_tag;

  // ====================
  // Resolver
  // ====================
  ip_resolver u_ip_resolver (
    .global_bus     (global_bus),
    .rst_n          (rst_n),
    .in_bundle      (in_bundle),
    .branch_resolve (branch_resolve),
    .src_tag        (src_tag),
    .alloc_tag_0    (alloc_tag_0),
    .alloc_tag_1    (alloc_tag_1),
    .avail          (avail),
    .src_reg        (src_reg),
    .alloc_num      (alloc_num),
    .map_wr_en      (map_wr_en),
    .map_wr_reg     (map_wr_reg),
    .map_wr_tag     (map_wr_tag),
    .out_bundle     (out_bundle),
    .stop           (stop)
  );

  // ====================
  // Rename state
  // ====================
  map_table u_map_table (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .rd_reg     (src_reg),
    .rd_tag     (src_tag),
    .wr_en      (map_wr_en),
    .wr_reg     (map_wr_reg),
    .wr_tag     (map_wr_tag)
  );

  free_list u_free_list (
    .global_bus  (global_bus),
    .rst_n       (rst_n),
    .alloc_num   (alloc_num),
    .free_valid  (free_valid),       // Tags back from commit
    .free_tag    (free_tag),
    .alloc_tag_0 (alloc_tag_0),
    .alloc_tag_1 (alloc_tag_1),
    .avail       (avail)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rename stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_rename_top -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log

grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log && exit 0 || exit 1

// ==== sources.f ====
+incdir+logic
logic/rename_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/ip_resolver.sv
logic/rename_top.sv
tests/tb_rename_top.sv

// ==== tests/tb_rename_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module tb_rename_top import rename_pkg::*; ();

  logic            global_bus;
  logic            rst_n;
  decoded_bundle_t in_bundle;
  logic            free_valid;
  phys_tag_t       free_tag;
  logic            branch_resolve;
  renamed_bundle_t out_bundle;
  logic            stop;

  // Reference model state
  phys_tag_t       model_map [`RN_ARCH_REGS];
  phys_tag_t       model_free [$];
  logic            model_tag_active;
  phys_tag_t       alloc_hist [$];     // Tags handed out and not yet freed
  renamed_bundle_t exp_q [$];
  int              errors = 0;
  int              checks = 0;
  int              seed = 32'hc7ae;

  rename_top u_rename_top (
    .global_bus     (global_bus),
    .rst_n          (rst_n),
    .in_bundle      (in_bundle),
    .free_valid     (free_valid),
    .free_tag       (free_tag),
    .branch_resolve (branch_resolve),
    .out_bundle     (out_bundle),
    .stop           (stop)
  );

  initial begin
    global_bus = 1'b0;
    forever #50 global_bus = ~global_bus;
  end

  // ====================
  // Checks and model
  // ====================
  task automatic check_bundle(input renamed_bundle_t got, input renamed_bundle_t exp,
                              input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_stop(input logic got, input logic exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
    end
  endtask

  function automatic renamed_bundle_t ref_rename(input decoded_bundle_t b,
                                                 output logic exp_stop);
    renamed_bundle_t r;
    logic            n0;
    logic            n1;
    int              need;
    n0 = b.slot_0.valid && b.slot_0.writes && (b.slot_0.rd != 0);
    n1 = b.slot_1.valid && b.slot_1.writes && (b.slot_1.rd != 0);
    need = int'(n0) + int'(n1);
    exp_stop = (b.slot_0.valid || b.slot_1.valid) && (need > model_free.size());
    r = '0;
    r.slot_0.valid   = b.slot_0.valid;
    r.slot_0.address = b.slot_0.address;
    r.slot_0.rs_1    = model_map[b.slot_0.rs_1];
    r.slot_0.rs_2    = model_map[b.slot_0.rs_2];
    r.slot_0.rd      = b.slot_0.rd;
    r.slot_0.writes  = b.slot_0.writes;
    r.slot_0.jumps   = b.slot_0.jumps;
    r.slot_0.tag     = b.slot_0.jumps ? 1'b0 : model_tag_active;
    if (n0 && model_free.size() > 0) r.slot_0.rn = model_free[0];
    if (n1 && n0 && model_free.size() > 1) r.slot_1.rn = model_free[1];
    if (n1 && !n0 && model_free.size() > 0) r.slot_1.rn = model_free[0];
    r.slot_1.valid   = b.slot_1.valid;
    r.slot_1.address = b.slot_1.address;
    r.slot_1.rs_1    = (n0 && b.slot_0.rd == b.slot_1.rs_1) ? r.slot_0.rn
                                                           : model_map[b.slot_1.rs_1];
    r.slot_1.rs_2    = (n0 && b.slot_0.rd == b.slot_1.rs_2) ? r.slot_0.rn
                                                           : model_map[b.slot_1.rs_2];
    r.slot_1.rd      = b.slot_1.rd;
    r.slot_1.writes  = b.slot_1.writes;
    r.slot_1.jumps   = b.slot_1.jumps;
    if (b.slot_1.jumps) r.slot_1.tag = 1'b0;
    else if (b.slot_0.jumps) r.slot_1.tag = 1'b1;
    else r.slot_1.tag = model_tag_active;
    return r;
  endfunction

  function automatic decoded_instr_t mk_instr(input int rs1, input int rs2, input int rd,
                                              input logic wr, input logic jmp);
    decoded_instr_t d;
    d.valid   = 1'b1;
    d.address = instr_addr_t'($random(seed));
    d.rs_1    = arch_reg_t'(rs1);
    d.rs_2    = arch_reg_t'(rs2);
    d.rd      = arch_reg_t'(rd);
    d.writes  = wr;
    d.jumps   = jmp;
    return d;
  endfunction

  // ====================
  // Driving
  // ====================
  task automatic drive_cycle(input decoded_bundle_t b, input logic fv, input phys_tag_t ft,
                             input logic rs, output logic accepted);
    renamed_bundle_t exp;
    logic            exp_stop;
    phys_tag_t       tmp;
    @(negedge global_bus);
    in_bundle      = b;
    free_valid     = fv;
    free_tag       = ft;
    branch_resolve = rs;
    #10;
    exp = ref_rename(b, exp_stop);
    check_stop(stop, exp_stop, "stop");
    accepted = (b.slot_0.valid || b.slot_1.valid) && !exp_stop;
    if (accepted) begin
      exp_q.push_back(exp);
      if (exp.slot_0.rn != 0) begin
        tmp = model_free.pop_front();
        model_map[b.slot_0.rd] = tmp;
        alloc_hist.push_back(tmp);
      end
      if (exp.slot_1.rn != 0) begin
        tmp = model_free.pop_front();
        model_map[b.slot_1.rd] = tmp;    // Younger slot overrides
        alloc_hist.push_back(tmp);
      end
    end
    if (accepted && ((b.slot_0.valid && b.slot_0.jumps) || (b.slot_1.valid && b.slot_1.jumps)))
      model_tag_active = 1'b1;
    else if (rs)
      model_tag_active = 1'b0;
    if (fv) model_free.push_back(ft);
  endtask

  task automatic send(input decoded_bundle_t b);
    logic acc;
    int   n;
    acc = 1'b0;
    n = 0;
    while (!acc) begin
      drive_cycle(b, 1'b0, '0, 1'b0, acc);
      n++;
      if (!acc && n > 20) begin
        $display("Timeout: bundle never accepted at %0t", $time);
        $display("sim failed");
        $finish;
      end
    end
  endtask

  task automatic wait_outputs();
    logic acc;
    int   n;
    n = 0;
    while (exp_q.size() != 0) begin
      drive_cycle('0, 1'b0, '0, 1'b0, acc);
      n++;
      if (n > 10) begin
        $display("Timeout: renamed output never appeared at %0t", $time);
        $display("sim failed");
        $finish;
      end
    end
  endtask

  task automatic end_test(input string name);
    wait_outputs();
    $display("%s finished, errors so far %0d", name, errors);
  endtask

  // Compares each output one edge after its accept
  initial begin
    @(posedge rst_n);
    forever begin
      @(negedge global_bus);
      if (exp_q.size() > 0) check_bundle(out_bundle, exp_q.pop_front(), "out_bundle");
      else check_stop(out_bundle.slot_0.valid | out_bundle.slot_1.valid, 1'b0, "idle valid");
    end
  end

  // ====================
  // Tests
  // ====================
  initial begin
    decoded_bundle_t b;
    logic            acc;
    int              n;
    rst_n = 1'b0;
    in_bundle = '0;
    free_valid = 1'b0;
    free_tag = '0;
    branch_resolve = 1'b0;
    model_tag_active = 1'b0;
    for (int i = 0; i < `RN_ARCH_REGS; i++) model_map[i] = phys_tag_t'(i);
    for (int i = `RN_ARCH_REGS; i < `RN_PHYS_REGS; i++) model_free.push_back(phys_tag_t'(i));
    repeat (16) @(posedge global_bus);
    @(negedge global_bus);
    rst_n = 1'b1;

    b = '0;
    b.slot_0 = mk_instr(5, 7, 9, 1'b0, 1'b0);
    send(b);
    b.slot_0 = mk_instr(31, 1, 0, 1'b0, 1'b0);
    send(b);
    end_test("reset identity");

    b = '0;
    b.slot_0 = mk_instr(1, 2, 3, 1'b1, 1'b0);   // rn 32
    send(b);
    b.slot_0 = mk_instr(3, 4, 4, 1'b1, 1'b0);   // rn 33
    send(b);
    b.slot_0 = mk_instr(3, 4, 0, 1'b1, 1'b0);   // r0 write
    send(b);
    b.slot_0 = mk_instr(3, 0, 6, 1'b0, 1'b0);
    send(b);
    end_test("sequential allocation");

    b.slot_0 = mk_instr(1, 2, 5, 1'b1, 1'b0);
    b.slot_1 = mk_instr(5, 5, 5, 1'b1, 1'b0);
    send(b);
    b.slot_0 = mk_instr(5, 5, 0, 1'b0, 1'b0);
    b.slot_1 = '0;
    send(b);
    end_test("in-bundle bypass");

    b.slot_0 = mk_instr(1, 2, 10, 1'b1, 1'b0);
    b.slot_1 = mk_instr(10, 3, 11, 1'b1, 1'b0);
    n = 0;
    acc = 1'b1;
    while (acc && n < 40) begin
      drive_cycle(b, 1'b0, '0, 1'b0, acc);
      n++;
    end
    check_stop(stop, 1'b1, "stop after drain");
    n = 0;
    while (!acc) begin
      drive_cycle(b, 1'b1, alloc_hist[n], 1'b0, acc);
      n++;
      if (!acc && n > 20) begin
        $display("Timeout: held bundle not released by freed tags");
        $display("sim failed");
        $finish;
      end
    end
    repeat (n) void'(alloc_hist.pop_front());
    end_test("free list drain");

    b.slot_0 = mk_instr(1, 2, 0, 1'b0, 1'b1);
    b.slot_1 = mk_instr(3, 4, 0, 1'b0, 1'b0);
    send(b);
    b.slot_1 = '0;
    b.slot_0 = mk_instr(5, 6, 0, 1'b0, 1'b0);
    send(b);
    b.slot_0 = mk_instr(7, 8, 0, 1'b0, 1'b1);   // Jump while the tag is set
    send(b);
    drive_cycle('0, 1'b0, '0, 1'b1, acc);
    b.slot_0 = mk_instr(5, 6, 0, 1'b0, 1'b0);
    send(b);
    end_test("speculation tag");

    for (int i = 0; i < 200; i++) begin
      b = '0;
      b.slot_0 = mk_instr($random(seed), $random(seed), $random(seed),
                          ($random(seed) & 3) != 0, ($random(seed) & 7) == 0);
      if (($random(seed) & 1) != 0)
        b.slot_1 = mk_instr($random(seed), $random(seed), $random(seed),
                            ($random(seed) & 3) != 0, ($random(seed) & 7) == 0);
      acc = 1'b0;
      n = 0;
      while (!acc) begin
        if (alloc_hist.size() > 0 && (n > 0 || ($random(seed) & 1) != 0))
          drive_cycle(b, 1'b1, alloc_hist.pop_front(), ($random(seed) & 7) == 0, acc);
        else
          drive_cycle(b, 1'b0, '0, ($random(seed) & 7) == 0, acc);
        n++;
        if (!acc && n > 40) begin
          $display("Timeout: random bundle %0d stuck on stop", i);
          $display("sim failed");
          $finish;
        end
      end
    end
    end_test("random run");

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
